/* mips_pkg.sv */
package mips_pkg;

	// Data, address and instruction words share one width
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// Primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0A,
		op_andi    = 6'h0C,
		op_ori     = 6'h0D,
		op_xori    = 6'h0E,
		op_lui     = 6'h0F,
		op_lw      = 6'h23,
		op_sw      = 6'h2B
	} opcode_t;

	// SPECIAL funct codes, bits 5:0
	typedef enum logic [5:0] {
		fn_sll   = 6'h00,
		fn_srl   = 6'h02,
		fn_sra   = 6'h03,
		fn_jr    = 6'h08,
		fn_mfhi  = 6'h10,
		fn_mflo  = 6'h12,
		fn_multu = 6'h19,
		fn_addu  = 6'h21,
		fn_subu  = 6'h23,
		fn_and   = 6'h24,
		fn_or    = 6'h25,
		fn_xor   = 6'h26,
		fn_slt   = 6'h2A,
		fn_sltu  = 6'h2B
	} funct_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
		alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_t;

	// Source of the register file write value
	typedef enum logic [2:0] {wb_alu, wb_mem, wb_link, wb_hi, wb_lo} wb_sel_t;

	localparam word_t reset_vector = 32'hBFC00000;
	// Jumping here ends the program
	localparam word_t halt_address = 32'h00000000;
	localparam reg_addr_t reg_v0 = 5'd2;
	localparam reg_addr_t reg_ra = 5'd31;

endpackage

/* mips_decode.sv */
module mips_decode (
	input  mips_pkg::word_t   instr,
	output mips_pkg::alu_op_t alu_op,
	output logic              alu_src_imm,
	output logic              imm_zero_ext,
	output logic              reg_write,
	output logic              reg_dst_rd,
	output logic              link,
	output logic              mem_read,
	output logic              mem_write,
	output logic              branch,
	output logic              branch_ne,
	output logic              jump,
	output logic              jump_reg,
	output logic              hilo_write,
	output mips_pkg::wb_sel_t wb_sel
);
	import mips_pkg::*;

	opcode_t opcode;
	funct_t  funct;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct = funct_t'(instr[5:0]);

	always_comb begin
		// Defaults describe a no-op
		alu_op = alu_add;
		alu_src_imm = 1'b0;
		imm_zero_ext = 1'b0;
		reg_write = 1'b0;
		reg_dst_rd = 1'b0;
		link = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		jump_reg = 1'b0;
		hilo_write = 1'b0;
		wb_sel = wb_alu;
		unique case (opcode)
			op_special: begin
				// R-type results go to rd
				reg_dst_rd = 1'b1;
				unique case (funct)
					fn_addu: begin
						alu_op = alu_add;
						reg_write = 1'b1;
					end
					fn_subu: begin
						alu_op = alu_sub;
						reg_write = 1'b1;
					end
					fn_and: begin
						alu_op = alu_and;
						reg_write = 1'b1;
					end
					fn_or: begin
						alu_op = alu_or;
						reg_write = 1'b1;
					end
					fn_xor: begin
						alu_op = alu_xor;
						reg_write = 1'b1;
					end
					fn_slt: begin
						alu_op = alu_slt;
						reg_write = 1'b1;
					end
					fn_sltu: begin
						alu_op = alu_sltu;
						reg_write = 1'b1;
					end
					fn_sll: begin
						alu_op = alu_sll;
						reg_write = 1'b1;
					end
					fn_srl: begin
						alu_op = alu_srl;
						reg_write = 1'b1;
					end
					fn_sra: begin
						alu_op = alu_sra;
						reg_write = 1'b1;
					end
					fn_jr: jump_reg = 1'b1;
					fn_multu: hilo_write = 1'b1;
					fn_mfhi: begin
						reg_write = 1'b1;
						wb_sel = wb_hi;
					end
					fn_mflo: begin
						reg_write = 1'b1;
						wb_sel = wb_lo;
					end
					default: reg_dst_rd = 1'b0;
				endcase
			end
			op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
				alu_src_imm = 1'b1;
				reg_write = 1'b1;
				// Logical immediates are zero extended
				imm_zero_ext = (opcode == op_andi) || (opcode == op_ori) ||
					(opcode == op_xori);
				unique case (opcode)
					op_slti: alu_op = alu_slt;
					op_andi: alu_op = alu_and;
					op_ori: alu_op = alu_or;
					op_xori: alu_op = alu_xor;
					op_lui: alu_op = alu_lui;
					default: alu_op = alu_add;
				endcase
			end
			op_lw: begin
				// Address is rs plus signed offset
				alu_src_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				wb_sel = wb_mem;
			end
			op_sw: begin
				alu_src_imm = 1'b1;
				mem_write = 1'b1;
			end
			op_beq: branch = 1'b1;
			op_bne: begin
				branch = 1'b1;
				branch_ne = 1'b1;
			end
			op_j: jump = 1'b1;
			op_jal: begin
				jump = 1'b1;
				link = 1'b1;
				reg_write = 1'b1;
				wb_sel = wb_link;
			end
			default: begin
			end
		endcase
	end

endmodule

/* mips_regfile.sv */
module mips_regfile (
	input  logic                clk,
	input  logic                reset,
	input  logic                enable,
	input  logic                write_enable,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	input  mips_pkg::reg_addr_t rd_addr,
	input  mips_pkg::word_t     rd_data,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data,
	output mips_pkg::word_t     register_v0
);
	import mips_pkg::*;

	word_t regs [32];

	// Register zero is never written, so it stays at its reset value
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (enable && write_enable && (rd_addr != 5'd0)) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// Combinational reads
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	// Tap for the result register
	assign register_v0 = regs[reg_v0];

endmodule

/* mips_alu.sv */
module mips_alu (
	input  mips_pkg::alu_op_t alu_op,
	input  logic              alu_src_imm,
	input  logic              imm_zero_ext,
	input  mips_pkg::word_t   rs_data,
	input  mips_pkg::word_t   rt_data,
	input  logic [15:0]       immediate,
	input  logic [4:0]        shamt,
	output mips_pkg::word_t   alu_result,
	output logic              equal,
	output mips_pkg::word_t   product_hi,
	output mips_pkg::word_t   product_lo
);
	import mips_pkg::*;

	word_t imm_ext;
	word_t operand_b;
	logic [63:0] product;

	// Immediate extension
	assign imm_ext = imm_zero_ext ? {16'h0000, immediate} : {{16{immediate[15]}}, immediate};

	// Second operand
	assign operand_b = alu_src_imm ? imm_ext : rt_data;

	always_comb begin
		unique case (alu_op)
			alu_add: alu_result = rs_data + operand_b;
			alu_sub: alu_result = rs_data - operand_b;
			alu_and: alu_result = rs_data & operand_b;
			alu_or: alu_result = rs_data | operand_b;
			alu_xor: alu_result = rs_data ^ operand_b;
			alu_slt: alu_result = {31'd0, $signed(rs_data) < $signed(operand_b)};
			alu_sltu: alu_result = {31'd0, rs_data < operand_b};
			// Shifts act on rt by the instruction's shamt field
			alu_sll: alu_result = operand_b << shamt;
			alu_srl: alu_result = operand_b >> shamt;
			alu_sra: alu_result = word_t'($signed(operand_b) >>> shamt);
			alu_lui: alu_result = {immediate, 16'h0000};
			default: alu_result = rs_data + operand_b;
		endcase
	end

	// Branch comparison always on the two registers
	assign equal = (rs_data == rt_data);

	// Unsigned 64-bit product for MULTU
	assign product = {32'd0, rs_data} * {32'd0, rt_data};
	assign product_hi = product[63:32];
	assign product_lo = product[31:0];

endmodule

/* mips_next_pc.sv */
module mips_next_pc (
	input  logic            clk,
	input  logic            reset,
	input  logic            enable,
	input  logic            branch,
	input  logic            branch_ne,
	input  logic            equal,
	input  logic            jump,
	input  logic            jump_reg,
	input  logic [15:0]     immediate,
	input  logic [25:0]     jump_target,
	input  mips_pkg::word_t rs_data,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t pc_plus4
);
	import mips_pkg::*;

	word_t branch_target;
	word_t jump_address;
	word_t pc_next;
	logic  taken;

	assign pc_plus4 = pc + 32'd4;

	// Word offset relative to the following instruction
	assign branch_target = pc_plus4 + {{14{immediate[15]}}, immediate, 2'b00};

	// Stays inside the current 256 MB region
	assign jump_address = {pc_plus4[31:28], jump_target, 2'b00};

	// BNE inverts the sense of the compare
	assign taken = branch && (branch_ne ? !equal : equal);

	always_comb begin
		if (jump_reg) begin
			pc_next = rs_data;
		end else if (jump) begin
			pc_next = jump_address;
		end else if (taken) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_vector;
		end else if (enable) begin
			pc <= pc_next;
		end
	end

endmodule

/* mips_writeback.sv */
module mips_writeback (
	input  logic              clk,
	input  logic              reset,
	input  logic              enable,
	input  logic              hilo_write,
	input  mips_pkg::wb_sel_t wb_sel,
	input  mips_pkg::word_t   alu_result,
	input  mips_pkg::word_t   mem_data,
	input  mips_pkg::word_t   pc_plus4,
	input  mips_pkg::word_t   product_hi,
	input  mips_pkg::word_t   product_lo,
	output mips_pkg::word_t   write_data
);
	import mips_pkg::*;

	word_t hi;
	word_t lo;

	// HI/LO load together on MULTU
	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (enable && hilo_write) begin
			hi <= product_hi;
			lo <= product_lo;
		end
	end

	// Register write value
	always_comb begin
		unique case (wb_sel)
			wb_alu: write_data = alu_result;
			wb_mem: write_data = mem_data;
			// Return address for JAL, no delay slot
			wb_link: write_data = pc_plus4;
			wb_hi: write_data = hi;
			wb_lo: write_data = lo;
			default: write_data = alu_result;
		endcase
	end

endmodule

/* mips_cpu_harvard.sv */
module mips_cpu_harvard (
	input  logic            clk,
	input  logic            reset,
	output logic            active,
	output mips_pkg::word_t register_v0,

	input  logic            clk_enable,

	output mips_pkg::word_t instr_address,
	input  mips_pkg::word_t instr_readdata,

	output mips_pkg::word_t data_address,
	output logic            data_write,
	output logic            data_read,
	output mips_pkg::word_t data_writedata,
	input  mips_pkg::word_t data_readdata
);
	import mips_pkg::*;

	alu_op_t alu_op;
	wb_sel_t wb_sel;
	logic alu_src_imm;
	logic imm_zero_ext;
	logic reg_write;
	logic reg_dst_rd;
	logic link;
	logic mem_read;
	logic mem_write;
	logic branch;
	logic branch_ne;
	logic jump;
	logic jump_reg;
	logic hilo_write;
	logic equal;
	logic enable;
	reg_addr_t dest;
	word_t rs_data;
	word_t rt_data;
	word_t alu_result;
	word_t product_hi;
	word_t product_lo;
	word_t pc;
	word_t pc_plus4;
	word_t write_data;

	// Drops on the edge that loads the halt address into the PC
	assign active = (pc != halt_address);

	// Halted core holds all state
	assign enable = clk_enable && active;

	// JAL links into ra
	assign dest = link ? reg_ra : (reg_dst_rd ? instr_readdata[15:11] : instr_readdata[20:16]);

	mips_decode u_decode (
		.instr(instr_readdata), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
		.imm_zero_ext(imm_zero_ext), .reg_write(reg_write), .reg_dst_rd(reg_dst_rd),
		.link(link), .mem_read(mem_read), .mem_write(mem_write), .branch(branch),
		.branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg),
		.hilo_write(hilo_write), .wb_sel(wb_sel)
	);

	mips_regfile u_regfile (
		.clk(clk), .reset(reset), .enable(enable), .write_enable(reg_write),
		.rs_addr(instr_readdata[25:21]), .rt_addr(instr_readdata[20:16]),
		.rd_addr(dest), .rd_data(write_data), .rs_data(rs_data), .rt_data(rt_data),
		.register_v0(register_v0)
	);

	mips_alu u_alu (
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
		.rs_data(rs_data), .rt_data(rt_data), .immediate(instr_readdata[15:0]),
		.shamt(instr_readdata[10:6]), .alu_result(alu_result), .equal(equal),
		.product_hi(product_hi), .product_lo(product_lo)
	);

	mips_next_pc u_next_pc (
		.clk(clk), .reset(reset), .enable(enable), .branch(branch),
		.branch_ne(branch_ne), .equal(equal), .jump(jump), .jump_reg(jump_reg),
		.immediate(instr_readdata[15:0]), .jump_target(instr_readdata[25:0]),
		.rs_data(rs_data), .pc(pc), .pc_plus4(pc_plus4)
	);

	mips_writeback u_writeback (
		.clk(clk), .reset(reset), .enable(enable), .hilo_write(hilo_write),
		.wb_sel(wb_sel), .alu_result(alu_result), .mem_data(data_readdata),
		.pc_plus4(pc_plus4), .product_hi(product_hi), .product_lo(product_lo),
		.write_data(write_data)
	);

	// Memory ports
	assign instr_address = pc;
	assign data_address = alu_result;
	assign data_writedata = rt_data;
	assign data_read = mem_read && active;
	assign data_write = mem_write && active;

endmodule

/* mips_cpu_tb_mem.sv */
module mips_cpu_tb_mem (
	input  logic            clk,
	input  logic            clk_enable,

	// Loading port used by the tests
	input  logic            load,
	input  logic            load_data_sel,
	input  logic [5:0]      load_index,
	input  mips_pkg::word_t load_value,

	input  mips_pkg::word_t instr_address,
	output mips_pkg::word_t instr_readdata,

	input  mips_pkg::word_t data_address,
	input  logic            data_write,
	input  logic            data_read,
	input  mips_pkg::word_t data_writedata,
	output mips_pkg::word_t data_readdata
);
	timeunit 1ns;
	timeprecision 100ps;
	import mips_pkg::*;

	// 64 words each, indexed by word address
	word_t instr_mem [64];
	word_t data_mem [64];
	word_t instr_offset;

	// Program word 0 sits at the reset vector
	assign instr_offset = instr_address - reset_vector;
	assign instr_readdata = instr_mem[instr_offset[7:2]];

	// Combinational read, zero when not requested
	assign data_readdata = data_read ? data_mem[data_address[7:2]] : '0;

	always_ff @(posedge clk) begin
		if (load) begin
			if (load_data_sel) begin
				data_mem[load_index] <= load_value;
			end else begin
				instr_mem[load_index] <= load_value;
			end
		end else if (clk_enable && data_write) begin
			// Store lands on the enabled edge only
			data_mem[data_address[7:2]] <= data_writedata;
		end
	end

endmodule

/* mips_cpu_tb.sv */
module mips_cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mips_pkg::*;

	// Operands for the ALU, shift and multiply programs
	localparam word_t op_a = 32'h8765_4321;
	localparam word_t op_b = 32'h1234_5678;
	// Up to 36 runs, each 20 load words, 10 reset cycles, 20 instructions doubled by stalls
	localparam int timeout_cycles = 36 * (20 + 10 + 2 * 20);

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	logic data_write;
	logic data_read;
	word_t data_writedata;
	word_t data_readdata;
	logic load;
	logic load_data_sel;
	logic [5:0] load_index;
	word_t load_value;

	word_t prog_words[$];
	int error_count;
	int store_count;
	int cycle_count;
	integer seed;

	mips_cpu_harvard mips_cpu_harvard_inst (
		.clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
		.clk_enable(clk_enable), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_address(data_address),
		.data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	mips_cpu_tb_mem mem_model (
		.clk(clk), .clk_enable(clk_enable), .load(load), .load_data_sel(load_data_sel),
		.load_index(load_index), .load_value(load_value), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_address(data_address),
		.data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Watchdog on total run length
	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: core did not halt within %0d cycles", timeout_cycles);
		$display("tests failed");
		$finish;
	end

	// MIPS instruction formats
	function automatic word_t encode_r(input int rs, input int rt, input int rd,
			input int shamt, input int funct);
		return (rs << 21) | (rt << 16) | (rd << 11) | (shamt << 6) | funct;
	endfunction

	function automatic word_t encode_i(input int op, input int rs, input int rt, input int imm);
		return (op << 26) | (rs << 21) | (rt << 16) | (imm & 'hFFFF);
	endfunction

	function automatic word_t encode_j(input int op, input word_t target);
		return (op << 26) | ((target >> 2) & 'h03FF_FFFF);
	endfunction

	// Unsigned 64-bit product by shift and add
	function automatic logic [63:0] unsigned_product(input word_t a, input word_t b);
		logic [63:0] sum;
		sum = '0;
		for (int i = 0; i < 32; i++) begin
			if (b[i]) begin
				sum = sum + ({32'd0, a} << i);
			end
		end
		return sum;
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic write_mem_word(input logic to_data, input int index, input word_t value);
		@(posedge clk);
		load <= 1'b1;
		load_data_sel <= to_data;
		load_index <= index[5:0];
		load_value <= value;
	endtask

	// Load prog_words under reset, release, run to the halt
	task automatic run_program(input string name, input bit stall);
		word_t last_v0;
		logic last_en;
		logic [31:0] rnd;
		@(posedge clk);
		reset <= 1'b1;
		clk_enable <= 1'b1;
		foreach (prog_words[i]) begin
			write_mem_word(1'b0, i, prog_words[i]);
		end
		@(posedge clk);
		load <= 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		store_count = 0;
		@(negedge clk);
		check_bit({name, " active after reset"}, 1'b1, active);
		while (active) begin
			// Sampled mid-cycle, these apply to the coming edge
			if (data_write && clk_enable) begin
				store_count++;
			end
			last_v0 = register_v0;
			last_en = clk_enable;
			@(posedge clk);
			if (stall) begin
				rnd = $random(seed);
				clk_enable <= rnd[0];
			end
			@(negedge clk);
			if (!last_en && register_v0 !== last_v0) begin
				$display("%s: register_v0 changed on an edge with clk_enable low", name);
				error_count++;
			end
		end
		@(posedge clk);
		clk_enable <= 1'b1;
		repeat (2) @(negedge clk);
		check_bit({name, " active after halt"}, 1'b0, active);
	endtask

	// Set $4 and $5, run two instructions, halt through JR $0
	task automatic run_pair(input string name, input word_t first, input word_t second,
			input word_t expected, input bit stall);
		prog_words = {};
		prog_words.push_back(encode_i('h0F, 0, 4, op_a >> 16));
		prog_words.push_back(encode_i('h0D, 4, 4, op_a));
		prog_words.push_back(encode_i('h0F, 0, 5, op_b >> 16));
		prog_words.push_back(encode_i('h0D, 5, 5, op_b));
		prog_words.push_back(first);
		prog_words.push_back(second);
		prog_words.push_back(encode_r(0, 0, 0, 0, 'h08));
		run_program(name, stall);
		check_word(name, expected, register_v0);
	endtask

	task automatic alu_tests(input bit stall);
		string tag;
		word_t slt_expect;
		word_t sltu_expect;
		word_t slti_expect;
		tag = stall ? "stalled " : "";
		slt_expect = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
		sltu_expect = (op_a < op_b) ? 32'd1 : 32'd0;
		// SLTI immediate 0x8000 sign-extends to -32768
		slti_expect = ($signed(op_a) < $signed(32'hFFFF_8000)) ? 32'd1 : 32'd0;
		run_pair({tag, "addiu"}, encode_i('h09, 4, 2, 'hFF00), 0, op_a + 32'hFFFF_FF00, stall);
		run_pair({tag, "addu"}, encode_r(4, 5, 2, 0, 'h21), 0, op_a + op_b, stall);
		run_pair({tag, "subu"}, encode_r(4, 5, 2, 0, 'h23), 0, op_a - op_b, stall);
		run_pair({tag, "and"}, encode_r(4, 5, 2, 0, 'h24), 0, op_a & op_b, stall);
		run_pair({tag, "or"}, encode_r(4, 5, 2, 0, 'h25), 0, op_a | op_b, stall);
		run_pair({tag, "xor"}, encode_r(4, 5, 2, 0, 'h26), 0, op_a ^ op_b, stall);
		run_pair({tag, "slt"}, encode_r(4, 5, 2, 0, 'h2A), 0, slt_expect, stall);
		run_pair({tag, "sltu"}, encode_r(4, 5, 2, 0, 'h2B), 0, sltu_expect, stall);
		// Logical immediates zero-extend
		run_pair({tag, "andi"}, encode_i('h0C, 4, 2, 'hF0F0), 0, op_a & 32'h0000_F0F0, stall);
		run_pair({tag, "ori"}, encode_i('h0D, 4, 2, 'h8001), 0, op_a | 32'h0000_8001, stall);
		run_pair({tag, "xori"}, encode_i('h0E, 4, 2, 'h8001), 0, op_a ^ 32'h0000_8001, stall);
		run_pair({tag, "slti"}, encode_i('h0A, 4, 2, 'h8000), 0, slti_expect, stall);
		run_pair({tag, "lui"}, encode_i('h0F, 0, 2, 'hABCD), 0, 32'hABCD_0000, stall);
		// $0 written first, then read back as zero
		run_pair({tag, "zero register"}, encode_i('h09, 4, 0, 7), encode_r(0, 5, 2, 0, 'h21),
			op_b, stall);
	endtask

	task automatic shift_tests();
		word_t sra_expect;
		sra_expect = $signed(op_a) >>> 12;
		run_pair("sll", encode_r(0, 4, 2, 4, 'h00), 0, op_a << 4, 1'b0);
		run_pair("srl", encode_r(0, 4, 2, 8, 'h02), 0, op_a >> 8, 1'b0);
		run_pair("sra", encode_r(0, 4, 2, 12, 'h03), 0, sra_expect, 1'b0);
	endtask

	task automatic memory_test();
		// Byte address 0x48 is word 18
		write_mem_word(1'b1, 18, ~op_a);
		run_pair("sw lw", encode_i('h2B, 0, 4, 'h48), encode_i('h23, 0, 2, 'h48), op_a, 1'b0);
		check_word("sw data word", op_a, mem_model.data_mem[18]);
		check_word("sw store count", 32'd1, word_t'(store_count));
	endtask

	task automatic control_flow_test();
		word_t corrupt;
		word_t expected;
		corrupt = encode_i('h09, 0, 2, 'h99);
		// Adds 1, 2, 4, 8, 16 on the right path, then the link address
		expected = 31 + reset_vector + 4 * 15;
		prog_words = {};
		prog_words.push_back(encode_i('h09, 0, 2, 1));
		prog_words.push_back(encode_i('h09, 0, 4, 5));
		prog_words.push_back(encode_i('h09, 0, 5, 5));
		prog_words.push_back(encode_i('h04, 4, 5, 1));
		prog_words.push_back(corrupt);
		prog_words.push_back(encode_i('h09, 2, 2, 2));
		prog_words.push_back(encode_i('h05, 4, 5, 1));
		prog_words.push_back(encode_i('h09, 2, 2, 4));
		prog_words.push_back(encode_i('h04, 4, 2, 1));
		prog_words.push_back(encode_i('h09, 2, 2, 8));
		prog_words.push_back(encode_i('h05, 4, 2, 1));
		prog_words.push_back(corrupt);
		prog_words.push_back(encode_j('h02, reset_vector + 4 * 14));
		prog_words.push_back(corrupt);
		prog_words.push_back(encode_j('h03, reset_vector + 4 * 17));
		prog_words.push_back(encode_r(2, 31, 2, 0, 'h21));
		prog_words.push_back(encode_r(0, 0, 0, 0, 'h08));
		// Subroutine, returns through JR $31
		prog_words.push_back(encode_i('h09, 2, 2, 16));
		prog_words.push_back(encode_r(31, 0, 0, 0, 'h08));
		prog_words.push_back(corrupt);
		run_program("control flow", 1'b0);
		check_word("control flow", expected, register_v0);
	endtask

	task automatic multiply_test();
		logic [63:0] product;
		product = unsigned_product(op_a, op_b);
		run_pair("multu mfhi", encode_r(4, 5, 0, 0, 'h19), encode_r(0, 0, 2, 0, 'h10),
			product[63:32], 1'b0);
		run_pair("multu mflo", encode_r(4, 5, 0, 0, 'h19), encode_r(0, 0, 2, 0, 'h12),
			product[31:0], 1'b0);
	endtask

	initial begin
		error_count = 0;
		seed = 32'h51e7_5929;
		reset <= 1'b1;
		clk_enable <= 1'b1;
		load <= 1'b0;
		load_data_sel <= 1'b0;
		load_index <= '0;
		load_value <= '0;
		alu_tests(1'b0);
		shift_tests();
		memory_test();
		control_flow_test();
		multiply_test();
		// Same ALU programs with random clk_enable
		alu_tests(1'b1);
		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* all.f */
mips_pkg.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_next_pc.sv
mips_writeback.sv
mips_cpu_harvard.sv
mips_cpu_tb_mem.sv
mips_cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module mips_cpu_tb --Mdir obj_dir -o mips_cpu_sim &&
./obj_dir/mips_cpu_sim | tee sim.log &&
! grep -q "tests failed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
